/* filelist.f */
+incdir+include
design/siege_pkg.sv
design/slot_if.sv
design/unit_dispatch.sv
design/unit_slot.sv
design/tower_siege.sv
design/siege_engine.sv
testbench/siege_assertions.sv
testbench/tb_siege_engine.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_siege_engine
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, whatever the simulator's exit code
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_siege_engine.sv */
`timescale 1ns/1ps
`include "siege_consts.svh"

module tb_siege_engine
    import siege_pkg::*;
();

    localparam int tick_period = 4;
    localparam int wait_limit  = 100;      // cycles for one handshake
    localparam int siege_limit = 20000;

    logic                  clk_25MHz;
    logic                  rst         = 1'b1;
    logic                  spawn_valid = 1'b0;
    unit_type_t            spawn_type  = ut_killer_bird;
    logic                  spawn_ready;
    logic                  hit_valid   = 1'b0;
    logic [`SLOT_W-1:0]    hit_slot    = '0;
    hp_t                   hit_dmg     = '0;
    logic                  tick        = 1'b0;
    logic [`NUM_SLOTS-1:0] alive_mask;
    hp_t                   tower_hp;
    logic                  game_lose;

    integer seed          = 32'h27d2;
    bit     checking      = 1'b0;
    int     tick_cnt      = 0;
    int     multi_strikes = 0;

    // reference model state
    logic [`NUM_SLOTS-1:0] m_alive;
    unit_type_t            m_type  [`NUM_SLOTS];
    int                    m_x     [`NUM_SLOTS];
    int                    m_hp    [`NUM_SLOTS];
    bit                    m_siege [`NUM_SLOTS];
    int                    m_n     [`NUM_SLOTS];   // ticks since entering range
    int                    m_tower;
    bit                    m_lose;

    siege_engine dut (.*);

    initial begin
        clk_25MHz = 1'b0;
        forever #20 clk_25MHz = ~clk_25MHz;
    end

    always @(negedge clk_25MHz) begin
        tick_cnt = (tick_cnt + 1) % tick_period;
        tick     = (tick_cnt == 0);
    end

    // blow lands cd+2 ticks into each cycle of 2*cd+4 ticks in range
    function automatic bit strike_due(unit_type_t t, int n);
        int cd;
        cd = int'(stat_cd(t));
        return (n % (2 * cd + 4)) == cd + 2;
    endfunction

    function automatic int lowest_free(logic [`NUM_SLOTS-1:0] busy);
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            if (!busy[i])
                return i;
        end
        return -1;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_equal(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic spawn_unit(unit_type_t t);
        int waited;
        waited      = 0;
        spawn_valid = 1'b1;
        spawn_type  = t;
        while (!spawn_ready && waited < wait_limit) begin
            @(negedge clk_25MHz);
            waited++;
        end
        if (!spawn_ready)
            fail_run("spawn request was never accepted");
        @(negedge clk_25MHz);      // transfer edge is behind us
        spawn_valid = 1'b0;
    endtask

    task automatic shoot(int slot, hp_t dmg);
        hit_valid = 1'b1;
        hit_slot  = slot[`SLOT_W-1:0];
        hit_dmg   = dmg;
        @(negedge clk_25MHz);
        hit_valid = 1'b0;
    endtask

    // ------------------------------------------------------------
    // reference model, one step per clock edge
    // ------------------------------------------------------------
    always @(posedge clk_25MHz) begin : model
        int free;
        int dmg;
        int strikes;
        free    = lowest_free(m_alive);
        dmg     = 0;
        strikes = 0;
        if (rst) begin
            m_alive = '0;
            m_tower = `TOWER_HP_INIT;
            m_lose  = 1'b0;
        end else begin
            m_lose = m_lose || (m_tower == 0);
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                if (spawn_valid && free == i) begin
                    m_alive[i] = 1'b1;
                    m_type[i]  = spawn_type;
                    m_x[i]     = `SPAWN_X;
                    m_hp[i]    = int'(stat_hp(spawn_type));
                    m_siege[i] = 1'b0;
                end else if (m_alive[i]) begin
                    if (tick && !m_siege[i]
                            && m_x[i] + int'(stat_range(m_type[i])) >= `TOWER_X) begin
                        m_siege[i] = 1'b1;
                        m_n[i]     = 0;
                    end
                    if (tick && m_siege[i]) begin
                        if (strike_due(m_type[i], m_n[i])) begin
                            dmg += int'(stat_atk(m_type[i]));
                            strikes++;
                        end
                        m_n[i]++;
                    end else if (tick) begin
                        m_x[i] += int'(stat_speed(m_type[i]));
                    end
                    // a killing shot still lets this edge's blow land
                    if (hit_valid && hit_slot == i && int'(hit_dmg) >= m_hp[i])
                        m_alive[i] = 1'b0;
                    else if (hit_valid && hit_slot == i)
                        m_hp[i] -= int'(hit_dmg);
                end
            end
            m_tower = (dmg >= m_tower) ? 0 : m_tower - dmg;
            if (strikes > 1)
                multi_strikes++;
        end
    end

    always @(negedge clk_25MHz) begin : compare
        if (checking) begin
            expect_equal("alive_mask", alive_mask, m_alive);
            expect_equal("spawn_ready", spawn_ready, ~&m_alive);
            expect_equal("tower_hp", tower_hp, m_tower);
            expect_equal("game_lose", game_lose, m_lose);
        end
    end

    initial begin : stimulus
        int waited;
        int s;
        int d;
        repeat (2) @(posedge clk_25MHz);
        @(negedge clk_25MHz);
        rst      = 1'b0;
        checking = 1'b1;
        expect_equal("tower_hp", tower_hp, `TOWER_HP_INIT);
        expect_equal("alive_mask", alive_mask, 0);
        expect_equal("spawn_ready", spawn_ready, 1);
        expect_equal("game_lose", game_lose, 0);

        // lowest slot first, then a ninth request has to wait
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            spawn_unit(unit_type_t'(i % 4));
            expect_equal("alive_mask", alive_mask, (1 << (i + 1)) - 1);
        end
        spawn_valid = 1'b1;
        spawn_type  = ut_white_bear;
        repeat (6) begin
            @(negedge clk_25MHz);
            expect_equal("spawn_ready", spawn_ready, 0);
        end
        shoot(5, '1);                 // frees slot 5
        spawn_unit(ut_white_bear);
        expect_equal("alive_mask", alive_mask, 8'hff);

        // random shots on live and dead slots
        repeat (40) begin
            s = $random(seed) & 7;
            d = ($random(seed) & 'h1ff) + 1;
            shoot(s, hp_t'(d));
        end

        // refill with mixed kinds and let the siege run out
        for (int i = 0; i < `NUM_SLOTS && spawn_ready; i++)
            spawn_unit(unit_type_t'($random(seed) & 3));
        expect_equal("alive_mask", alive_mask, 8'hff);
        waited = 0;
        while (!game_lose && waited < siege_limit) begin
            @(negedge clk_25MHz);
            waited++;
        end
        if (!game_lose)
            fail_run("tower never fell within the siege time limit");
        repeat (20) @(negedge clk_25MHz);
        expect_equal("tower_hp", tower_hp, 0);
        expect_equal("game_lose", game_lose, 1);
        if (multi_strikes == 0)
            fail_run("no tick had several slots striking together");

        if (dut.u_checks.fail_count != 0) begin
            fail_run("a bound assertion fired during the run");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* testbench/siege_assertions.sv */
`timescale 1ns/1ps
`include "siege_consts.svh"

module siege_assertions
    import siege_pkg::*;
(
    input logic                  clk_25MHz,
    input logic                  rst,
    input logic                  spawn_valid,
    input unit_type_t            spawn_type,
    input logic                  spawn_ready,
    input logic [`NUM_SLOTS-1:0] alive_mask,
    input hp_t                   tower_hp,
    input logic                  game_lose
);

    int fail_count = 0;    // polled by the testbench before it ends

    // ------------------------------------------------------------
    // spawn handshake
    // ------------------------------------------------------------
    a_ready_full: assert property (@(posedge clk_25MHz) disable iff (rst)
        !spawn_ready |-> &alive_mask)
    else begin
        fail_count++;
        $error("spawn_ready low while a slot is free");
    end

    a_type_hold: assert property (@(posedge clk_25MHz) disable iff (rst)
        (spawn_valid && !spawn_ready) |=> $stable(spawn_type))
    else begin
        fail_count++;
        $error("spawn_type changed while the request waited");
    end

    // ------------------------------------------------------------
    // tower
    // ------------------------------------------------------------
    a_hp_down: assert property (@(posedge clk_25MHz) disable iff (rst)
        tower_hp <= $past(tower_hp))
    else begin
        fail_count++;
        $error("tower_hp went up");
    end

    // loss flag trails an empty tower by one cycle
    a_lose: assert property (@(posedge clk_25MHz) disable iff (rst)
        !$past(rst) |-> (game_lose == ($past(tower_hp) == '0)))
    else begin
        fail_count++;
        $error("game_lose out of step with tower_hp");
    end

endmodule

bind siege_engine siege_assertions u_checks (
    .clk_25MHz   (clk_25MHz),
    .rst         (rst),
    .spawn_valid (spawn_valid),
    .spawn_type  (spawn_type),
    .spawn_ready (spawn_ready),
    .alive_mask  (alive_mask),
    .tower_hp    (tower_hp),
    .game_lose   (game_lose)
);

/* design/siege_engine.sv */
`timescale 1ns/1ps
`include "siege_consts.svh"

module siege_engine
    import siege_pkg::*;
(
    input  logic                  rst,
    input  logic                  clk_25MHz,

    // spawn request
    input  logic                  spawn_valid,
    input  unit_type_t            spawn_type,
    output logic                  spawn_ready,

    // defender shots
    input  logic                  hit_valid,
    input  logic [`SLOT_W-1:0]    hit_slot,
    input  hp_t                   hit_dmg,

    input  logic                  tick,         // one game step

    output logic [`NUM_SLOTS-1:0] alive_mask,
    output hp_t                   tower_hp,
    output logic                  game_lose
);

    slot_if slots [`NUM_SLOTS] ();

    unit_dispatch u_dispatch (
        .spawn_valid (spawn_valid),
        .spawn_type  (spawn_type),
        .spawn_ready (spawn_ready),
        .hit_valid   (hit_valid),
        .hit_slot    (hit_slot),
        .hit_dmg     (hit_dmg),
        .slots       (slots)
    );

    // ------------------------------------------------------------
    // unit slots
    // ------------------------------------------------------------
    for (genvar g = 0; g < `NUM_SLOTS; g++) begin : g_slot
        unit_slot u_slot (
            .clk_25MHz (clk_25MHz),
            .rst       (rst),
            .tick      (tick),
            .u         (slots[g])
        );

        assign alive_mask[g] = slots[g].alive;
    end

    tower_siege u_tower (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .slots     (slots),
        .tower_hp  (tower_hp),
        .game_lose (game_lose)
    );

endmodule

/* design/tower_siege.sv */
`timescale 1ns/1ps
`include "siege_consts.svh"

module tower_siege
    import siege_pkg::*;
(
    input  logic  clk_25MHz,
    input  logic  rst,
    slot_if.tower slots [`NUM_SLOTS],
    output hp_t   tower_hp,
    output logic  game_lose
);

    localparam int sum_w = `HP_W + `SLOT_W;   // eight full blows fit

    hp_t              dmg [`NUM_SLOTS];
    logic [sum_w-1:0] dmg_sum;

    for (genvar g = 0; g < `NUM_SLOTS; g++) begin : g_dmg
        assign dmg[g] = slots[g].strike ? slots[g].strike_dmg : '0;
    end

    // several slots may strike on the same tick
    always_comb begin
        dmg_sum = '0;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            dmg_sum = dmg_sum + sum_w'(dmg[i]);
        end
    end

    // ------------------------------------------------------------
    // tower hit points and loss flag
    // ------------------------------------------------------------
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            tower_hp  <= hp_t'(`TOWER_HP_INIT);
            game_lose <= 1'b0;
        end else begin
            if (dmg_sum >= sum_w'(tower_hp)) begin
                tower_hp <= '0;          // saturate, never wrap
            end else begin
                tower_hp <= tower_hp - hp_t'(dmg_sum);
            end
            if (tower_hp == '0) begin
                game_lose <= 1'b1;       // sticky until reset
            end
        end
    end

endmodule

/* design/unit_slot.sv */
`timescale 1ns/1ps
`include "siege_consts.svh"

module unit_slot
    import siege_pkg::*;
(
    input  logic clk_25MHz,
    input  logic rst,
    input  logic tick,
    slot_if.slot u
);

    // control state
    logic        alive;
    unit_state_t state;
    cnt_t        cnt;

    // unit payload
    unit_type_t  utype;
    xpos_t       xpos;
    hp_t         hp;

    logic [`X_W:0] reach;      // spare bit keeps the sum from wrapping
    logic          in_range;
    cnt_t          cd;

    assign reach    = xpos + stat_range(utype);
    assign in_range = (reach >= `TOWER_X);
    assign cd       = stat_cd(utype);

    assign u.alive      = alive;
    assign u.strike     = alive && (state == st_strike) && tick;
    assign u.strike_dmg = stat_atk(utype);

    // ------------------------------------------------------------
    // spawn, damage and the march/attack FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            alive <= 1'b0;
            state <= st_move;
            cnt   <= '0;
        end else if (u.load) begin
            alive <= 1'b1;
            utype <= u.load_type;
            xpos  <= xpos_t'(`SPAWN_X);
            hp    <= stat_hp(u.load_type);
            state <= st_move;
            cnt   <= '0;
        end else if (alive) begin
            if (u.hit) begin
                if (u.hit_dmg >= hp) begin
                    alive <= 1'b0;      // killed on this edge
                end else begin
                    hp <= hp - u.hit_dmg;
                end
            end

            if (tick) begin
                case (state)
                    st_move: begin
                        if (in_range) begin
                            state <= st_wind;
                            cnt   <= '0;
                        end else begin
                            xpos <= xpos + stat_speed(utype);
                        end
                    end

                    st_wind: begin
                        if (cnt == cd) begin
                            state <= st_strike;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end

                    st_strike: begin
                        state <= st_recover;    // blow lands this tick
                        cnt   <= '0;
                    end

                    st_recover: begin
                        if (cnt == cd) begin
                            state <= st_move;   // recheck range next tick
                            cnt   <= '0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end

                    default: begin
                        state <= st_move;
                        cnt   <= '0;
                    end
                endcase
            end
        end
    end

endmodule

/* design/unit_dispatch.sv */
`timescale 1ns/1ps
`include "siege_consts.svh"

module unit_dispatch
    import siege_pkg::*;
(
    input  logic               spawn_valid,
    input  unit_type_t         spawn_type,
    output logic               spawn_ready,
    input  logic               hit_valid,
    input  logic [`SLOT_W-1:0] hit_slot,
    input  hp_t                hit_dmg,
    slot_if.dispatch           slots [`NUM_SLOTS]
);

    logic [`NUM_SLOTS-1:0] alive_vec;
    logic [`NUM_SLOTS-1:0] free_first;    // one-hot, lowest dead slot
    logic                  spawn_fire;

    // ------------------------------------------------------------
    // spawn side
    // ------------------------------------------------------------

    // walk down from the top so the lowest free slot wins
    always_comb begin
        free_first = '0;
        for (int i = `NUM_SLOTS - 1; i >= 0; i--) begin
            if (!alive_vec[i]) begin
                free_first    = '0;
                free_first[i] = 1'b1;
            end
        end
    end

    assign spawn_ready = ~&alive_vec;              // some slot is free
    assign spawn_fire  = spawn_valid & spawn_ready;

    // ------------------------------------------------------------
    // per slot routing
    // ------------------------------------------------------------
    for (genvar g = 0; g < `NUM_SLOTS; g++) begin : g_route
        localparam logic [`SLOT_W-1:0] slot_idx = g;

        assign alive_vec[g]       = slots[g].alive;
        assign slots[g].load      = spawn_fire & free_first[g];
        assign slots[g].load_type = spawn_type;
        assign slots[g].hit       = hit_valid && (hit_slot == slot_idx);
        assign slots[g].hit_dmg   = hit_dmg;   // slot ignores it unless hit
    end

endmodule

/* design/slot_if.sv */
`timescale 1ns/1ps

interface slot_if import siege_pkg::*; ();

    // from the dispatcher
    logic       load;        // spawn into this slot
    unit_type_t load_type;
    logic       hit;
    hp_t        hit_dmg;

    // from the slot
    logic       alive;
    logic       strike;      // high on the tick that lands a blow
    hp_t        strike_dmg;

    modport dispatch (
        output load, load_type, hit, hit_dmg,
        input  alive
    );

    modport slot (
        input  load, load_type, hit, hit_dmg,
        output alive, strike, strike_dmg
    );

    modport tower (
        input  strike, strike_dmg
    );

endinterface

/* design/siege_pkg.sv */
`include "siege_consts.svh"

package siege_pkg;

    typedef enum logic [1:0] {
        ut_killer_bird,
        ut_white_bear,
        ut_metal_duck,
        ut_black_bear
    } unit_type_t;

    typedef enum logic [2:0] {
        st_move,
        st_wind,     // counting up to the blow
        st_strike,
        st_recover
    } unit_state_t;

    typedef logic [`HP_W-1:0]  hp_t;
    typedef logic [`X_W-1:0]   xpos_t;
    typedef logic [`CNT_W-1:0] cnt_t;

    // ------------------------------------------------------------
    // stat lookup
    // ------------------------------------------------------------
    function automatic hp_t stat_hp(unit_type_t t);
        case (t)
            ut_killer_bird: return hp_t'(`KILLER_BIRD_HP);
            ut_white_bear:  return hp_t'(`WHITE_BEAR_HP);
            ut_metal_duck:  return hp_t'(`METAL_DUCK_HP);
            default:        return hp_t'(`BLACK_BEAR_HP);
        endcase
    endfunction

    function automatic hp_t stat_atk(unit_type_t t);
        case (t)
            ut_killer_bird: return hp_t'(`KILLER_BIRD_ATK);
            ut_white_bear:  return hp_t'(`WHITE_BEAR_ATK);
            ut_metal_duck:  return hp_t'(`METAL_DUCK_ATK);
            default:        return hp_t'(`BLACK_BEAR_ATK);
        endcase
    endfunction

    function automatic cnt_t stat_cd(unit_type_t t);
        case (t)
            ut_killer_bird: return cnt_t'(`KILLER_BIRD_CD);
            ut_white_bear:  return cnt_t'(`WHITE_BEAR_CD);
            ut_metal_duck:  return cnt_t'(`METAL_DUCK_CD);
            default:        return cnt_t'(`BLACK_BEAR_CD);
        endcase
    endfunction

    function automatic xpos_t stat_speed(unit_type_t t);
        case (t)
            ut_killer_bird: return xpos_t'(`KILLER_BIRD_SPEED);
            ut_white_bear:  return xpos_t'(`WHITE_BEAR_SPEED);
            ut_metal_duck:  return xpos_t'(`METAL_DUCK_SPEED);
            default:        return xpos_t'(`BLACK_BEAR_SPEED);
        endcase
    endfunction

    function automatic xpos_t stat_range(unit_type_t t);
        case (t)
            ut_killer_bird: return xpos_t'(`KILLER_BIRD_RANGE);
            ut_white_bear:  return xpos_t'(`WHITE_BEAR_RANGE);
            ut_metal_duck:  return xpos_t'(`METAL_DUCK_RANGE);
            default:        return xpos_t'(`BLACK_BEAR_RANGE);
        endcase
    endfunction

endpackage

/* include/siege_consts.svh */
`ifndef SIEGE_CONSTS_SVH
`define SIEGE_CONSTS_SVH

// ------------------------------------------------------------
// lane geometry and widths
// ------------------------------------------------------------
`define NUM_SLOTS     8
`define SLOT_W        3
`define X_W           10
`define HP_W          12
`define CNT_W         4        // holds the largest cd
`define SPAWN_X       10
`define TOWER_X       570
`define TOWER_HP_INIT 4000

// ------------------------------------------------------------
// unit stat table
// ------------------------------------------------------------
`define KILLER_BIRD_HP    100
`define KILLER_BIRD_ATK   20
`define KILLER_BIRD_CD    2
`define KILLER_BIRD_SPEED 8
`define KILLER_BIRD_RANGE 20

`define WHITE_BEAR_HP     300
`define WHITE_BEAR_ATK    40
`define WHITE_BEAR_CD     4
`define WHITE_BEAR_SPEED  4
`define WHITE_BEAR_RANGE  10

`define METAL_DUCK_HP     600
`define METAL_DUCK_ATK    15
`define METAL_DUCK_CD     3
`define METAL_DUCK_SPEED  2
`define METAL_DUCK_RANGE  30

`define BLACK_BEAR_HP     900
`define BLACK_BEAR_ATK    80
`define BLACK_BEAR_CD     6
`define BLACK_BEAR_SPEED  3
`define BLACK_BEAR_RANGE  10

`endif
